/* include/rob_settings.svh */
// Sizing macros for the read-response reorder shim
// Slot count and reserve for almost-full back-pressure
// Address, tag and data widths of the read channel

`ifndef ROB_SETTINGS_SVH
`define ROB_SETTINGS_SVH

// Number of reorder slots, which also bounds the reads in flight
// Keep this a power of two so the slot pointers wrap on their own
`define ROB_ENTRIES 16

// Free slots held back once almost-full is raised
// The client may still issue this many minus one requests after it rises
`define ROB_MIN_FREE 4

// Read channel field widths
`define ADDR_WIDTH 32
`define MDATA_WIDTH 12
`define LINE_WIDTH 64

`endif

/* src/rob_pkg.sv */
// Shared types for the read-response reorder shim
// Vector typedefs for addresses, tags, data words and slot indices
// Packed read request and read response structs

`include "rob_settings.svh"

package rob_pkg;

    // ==================================================
    // Plain vector types
    // ==================================================

    // Read address as issued by the client
    typedef logic [`ADDR_WIDTH-1:0] t_addr;

    // Client tag; toward memory the same field carries a slot index
    typedef logic [`MDATA_WIDTH-1:0] t_mdata;

    // One data word of a read response
    typedef logic [`LINE_WIDTH-1:0] t_line;

    // Index of one reorder slot
    typedef logic [$clog2(`ROB_ENTRIES)-1:0] t_rob_idx;

    // ==================================================
    // Channel structs
    // ==================================================

    // Read request, taken on every cycle where valid is high
    typedef struct packed {
        logic   valid;
        t_addr  addr;
        t_mdata mdata;
    } t_rd_req;

    // Read response, one valid strobe per response and no stall
    typedef struct packed {
        logic   valid;
        logic   error;
        t_mdata mdata;
        t_line  data;
    } t_rd_rsp;

endpackage

/* src/rd_req_tagger.sv */
// Request side of the reorder shim
// Swaps the client tag for the allocated slot index
// Raises the slot allocation strobe toward the store
// Combines memory and store back-pressure into client almost-full

`include "rob_settings.svh"

`timescale 1ns/1ps

module rd_req_tagger
(
    input  logic             clk,
    input  logic             reset,

    // Client request channel
    input  rob_pkg::t_rd_req client_req,
    input  logic             mem_almost_full,

    // Slot allocation handshake with the store
    input  rob_pkg::t_rob_idx alloc_idx,
    input  logic             not_full,
    output logic             alloc_en,

    // Request toward memory and back-pressure toward the client
    output rob_pkg::t_rd_req mem_req,
    output logic             client_almost_full
);

    // ==================================================
    // Tag replacement
    // ==================================================

    // Every valid request claims the slot at the store's tail
    // The store saves the client's tag there in the same cycle
    assign alloc_en = client_req.valid;

    // The request passes through in the same cycle
    // Only the tag changes, zero-extended from the slot index
    always_comb
    begin
        mem_req = client_req;
        mem_req.mdata = rob_pkg::t_mdata'(alloc_idx);
    end

    // ==================================================
    // Back-pressure
    // ==================================================

    // The store keeps ROB_MIN_FREE slots in reserve once not_full drops,
    // so the client may finish the requests already on their way
    assign client_almost_full = mem_almost_full || !not_full;

    // A well-behaved client stops within ROB_MIN_FREE - 1 cycles of not_full
    // dropping; a request after that could land on a slot still in use
    assert property (@(posedge clk) disable iff (reset)
        (!not_full) [*`ROB_MIN_FREE] |-> !client_req.valid)
        else $error("Request issued after the slot reserve was used up");

endmodule

/* src/rob_store.sv */
// Reorder store of the read-response shim
// Tag array written at allocation, data and error arrays written by responses
// Per-slot fill flags, head and tail pointers and the occupancy count
// Dequeue decision and registered head outputs

`include "rob_settings.svh"

`timescale 1ns/1ps

module rob_store
(
    input  logic              clk,
    input  logic              reset,

    // Allocation from the request side
    input  logic              alloc_en,
    input  rob_pkg::t_mdata   alloc_mdata,
    output rob_pkg::t_rob_idx alloc_idx,
    output logic              not_full,

    // Responses from memory, mdata holds the slot index
    input  rob_pkg::t_rd_rsp  mem_rsp,

    // Dequeue toward the response sequencer
    output logic              deq_en,
    output rob_pkg::t_mdata   head_mdata,
    output logic              head_error,
    output rob_pkg::t_line    head_data
);

    // Occupancy must reach ROB_ENTRIES itself, hence one extra bit
    localparam int CNT_W = $clog2(`ROB_ENTRIES) + 1;

    // Slot storage
    rob_pkg::t_mdata tag_mem  [`ROB_ENTRIES];
    logic            err_mem  [`ROB_ENTRIES];
    rob_pkg::t_line  data_mem [`ROB_ENTRIES];
    logic [`ROB_ENTRIES-1:0] filled;

    // Pointers and occupancy
    rob_pkg::t_rob_idx head;
    rob_pkg::t_rob_idx tail;
    logic [CNT_W-1:0]  count;

    // Registered memory response and the slot it targets
    rob_pkg::t_rd_rsp  rsp_q;
    rob_pkg::t_rob_idx rsp_idx;
    rob_pkg::t_rob_idx rsp_offset;
    logic              head_wr;

    // ==================================================
    // Response capture
    // ==================================================

    // Responses are registered once before they touch the arrays
    // Only the valid bit needs a reset
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rsp_q.valid <= 1'b0;
        end
        else
        begin
            rsp_q.valid <= mem_rsp.valid;
        end
        rsp_q.error <= mem_rsp.error;
        rsp_q.mdata <= mem_rsp.mdata;
        rsp_q.data  <= mem_rsp.data;
    end

    // The upper tag bits are zero on the memory side
    assign rsp_idx = rob_pkg::t_rob_idx'(rsp_q.mdata);

    // A response written to the head slot can leave in the same cycle
    assign head_wr = rsp_q.valid && (rsp_idx == head);

    // ==================================================
    // Allocation and dequeue decision
    // ==================================================

    assign alloc_idx = tail;

    // Keep ROB_MIN_FREE slots back for requests already in flight
    assign not_full = (count < CNT_W'(`ROB_ENTRIES - `ROB_MIN_FREE));

    // Release strictly in allocation order, whenever the head holds data
    assign deq_en = filled[head] || head_wr;

    // Tags are saved at the tail as requests go out
    always_ff @(posedge clk)
    begin
        if (alloc_en)
        begin
            tag_mem[tail] <= alloc_mdata;
        end
    end

    // Response payload lands in its slot, in whatever order it returns
    always_ff @(posedge clk)
    begin
        if (rsp_q.valid)
        begin
            err_mem[rsp_idx]  <= rsp_q.error;
            data_mem[rsp_idx] <= rsp_q.data;
        end
    end

    // Control state: pointers, count and fill flags
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            head   <= '0;
            tail   <= '0;
            count  <= '0;
            filled <= '0;
        end
        else
        begin
            if (alloc_en)
            begin
                tail <= tail + 1'b1;
            end
            if (deq_en)
            begin
                head <= head + 1'b1;
            end
            count <= count + CNT_W'(alloc_en) - CNT_W'(deq_en);

            // Clearing the head comes last, so a bypassed write leaves it free
            if (rsp_q.valid)
            begin
                filled[rsp_idx] <= 1'b1;
            end
            if (deq_en)
            begin
                filled[head] <= 1'b0;
            end
        end
    end

    // ==================================================
    // Head outputs
    // ==================================================

    // Fields of the dequeued slot appear one cycle after deq_en
    // A response written to the head this cycle is taken from the bypass
    always_ff @(posedge clk)
    begin
        if (deq_en)
        begin
            head_mdata <= tag_mem[head];
            head_error <= head_wr ? rsp_q.error : err_mem[head];
            head_data  <= head_wr ? rsp_q.data : data_mem[head];
        end
    end

    // Distance of the responding slot from the head, used to tell live slots
    assign rsp_offset = rsp_idx - head;

    // A response may only fill a slot that is allocated and still empty
    assert property (@(posedge clk) disable iff (reset)
        rsp_q.valid |-> (({1'b0, rsp_offset} < count) && !filled[rsp_idx]))
        else $error("Memory response targets a free or already filled slot");

    // The request side must never allocate past the last slot
    assert property (@(posedge clk) disable iff (reset)
        alloc_en |-> (count != CNT_W'(`ROB_ENTRIES)))
        else $error("Slot allocation overflows the reorder store");

endmodule

/* src/rd_rsp_sequencer.sv */
// Response side of the reorder shim
// Tracks when the store's head outputs hold a dequeued slot
// Rebuilds the client response with the original tag restored

`timescale 1ns/1ps

module rd_rsp_sequencer
(
    input  logic             clk,
    input  logic             reset,

    // Dequeued slot from the store with fields valid one cycle after deq_en
    input  logic             deq_en,
    input  rob_pkg::t_mdata  head_mdata,
    input  logic             head_error,
    input  rob_pkg::t_line   head_data,

    // Ordered response toward the client
    output rob_pkg::t_rd_rsp client_rsp
);

    // First stage of the dequeue delay line
    // High in the cycle where the store's head outputs are current
    logic deq_q;

    // ==================================================
    // Dequeue tracking
    // ==================================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            deq_q <= 1'b0;
        end
        else
        begin
            deq_q <= deq_en;
        end
    end

    // ==================================================
    // Response register
    // ==================================================

    // The valid strobe is the second stage of the delay line
    // Payload only loads on a dequeue and holds otherwise
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            client_rsp.valid <= 1'b0;
        end
        else
        begin
            client_rsp.valid <= deq_q;
        end

        if (deq_q)
        begin
            // The stored tag is the one the client sent
            client_rsp.mdata <= head_mdata;
            client_rsp.error <= head_error;
            client_rsp.data  <= head_data;
        end
    end

endmodule

/* src/rob_rd_shim.sv */
// Top level of the read-response reorder shim
// Request tagger, reorder store and response sequencer
// Client requests go out tagged with slot indices, responses return in order

`timescale 1ns/1ps

module rob_rd_shim
(
    input  logic             clk,
    input  logic             reset,

    // Client side
    input  rob_pkg::t_rd_req client_req,
    output logic             client_almost_full,
    output rob_pkg::t_rd_rsp client_rsp,

    // Memory side
    output rob_pkg::t_rd_req mem_req,
    input  logic             mem_almost_full,
    input  rob_pkg::t_rd_rsp mem_rsp
);

    // Allocation between the tagger and the store
    rob_pkg::t_rob_idx alloc_idx;
    logic              alloc_en;
    logic              not_full;

    // Dequeued slot between the store and the sequencer
    logic              deq_en;
    rob_pkg::t_mdata   head_mdata;
    logic              head_error;
    rob_pkg::t_line    head_data;

    // ==================================================
    // Request side
    // ==================================================

    rd_req_tagger u_rd_req_tagger
    (
        .clk                (clk),
        .reset              (reset),
        .client_req         (client_req),
        .mem_almost_full    (mem_almost_full),
        .alloc_idx          (alloc_idx),
        .not_full           (not_full),
        .alloc_en           (alloc_en),
        .mem_req            (mem_req),
        .client_almost_full (client_almost_full)
    );

    // ==================================================
    // Reorder store
    // ==================================================

    // The client's own tag is saved while the tagger swaps it out
    rob_store u_rob_store
    (
        .clk         (clk),
        .reset       (reset),
        .alloc_en    (alloc_en),
        .alloc_mdata (client_req.mdata),
        .alloc_idx   (alloc_idx),
        .not_full    (not_full),
        .mem_rsp     (mem_rsp),
        .deq_en      (deq_en),
        .head_mdata  (head_mdata),
        .head_error  (head_error),
        .head_data   (head_data)
    );

    // ==================================================
    // Response side
    // ==================================================

    rd_rsp_sequencer u_rd_rsp_sequencer
    (
        .clk        (clk),
        .reset      (reset),
        .deq_en     (deq_en),
        .head_mdata (head_mdata),
        .head_error (head_error),
        .head_data  (head_data),
        .client_rsp (client_rsp)
    );

endmodule

/* testbench/tb_rob_rd_shim.sv */
// Testbench for the read-response reorder shim
// Random client that keeps an expected-order queue
// Out-of-order memory model with random almost-full pulses
// Scoreboard for order, tag restore, payload, flow control and drain

`include "rob_settings.svh"

`timescale 1ns/1ps

module tb_rob_rd_shim;

    // Length of the run and the limits of each wait loop
    localparam int NUM_REQS      = 400;
    localparam int ISSUE_TIMEOUT = 20000;
    localparam int DRAIN_TIMEOUT = 2000;

    // Memory data is the address mixed with this key
    localparam logic [`LINE_WIDTH-1:0] DATA_KEY = 64'h5a5a_c3c3_0ff0_9669;

    logic             clk;
    logic             reset;
    rob_pkg::t_rd_req client_req;
    logic             client_almost_full;
    rob_pkg::t_rd_rsp client_rsp;
    rob_pkg::t_rd_req mem_req;
    logic             mem_almost_full;
    rob_pkg::t_rd_rsp mem_rsp;

    // Galois LFSR state that only the per-cycle model steps
    logic [31:0] lfsr_state = 32'h13ea;

    // Counters shared between the sequence and the per-cycle model
    int   errors;
    int   sent;
    int   issued;
    int   received;
    logic issue_en;

    // Samples from the two previous edges for the delayed almost-full check
    int   issued_hist [2];
    logic af_hist     [2];
    logic maf_hist    [2];
    int   hist_count;

    // Requests in the order the client sent them
    rob_pkg::t_rd_req expected_q[$];

    // Slots the memory has seen but not yet answered, with their addresses
    rob_pkg::t_rob_idx pending_q[$];
    rob_pkg::t_addr    slot_addr [`ROB_ENTRIES];

    rob_rd_shim u_rob_rd_shim
    (
        .clk                (clk),
        .reset              (reset),
        .client_req         (client_req),
        .client_almost_full (client_almost_full),
        .client_rsp         (client_rsp),
        .mem_req            (mem_req),
        .mem_almost_full    (mem_almost_full),
        .mem_rsp            (mem_rsp)
    );

    // 8 ns clock period
    always
    begin
        #4 clk = ~clk;
    end

    // ==================================================
    // Helpers
    // ==================================================

    // Takes n bits from the LFSR with one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        int          i;
        value = '0;
        for (i = 0; i < n; i++)
        begin
            value = {value[30:0], lfsr_state[0]};
            if (lfsr_state[0])
            begin
                lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
            end
            else
            begin
                lfsr_state = lfsr_state >> 1;
            end
        end
        return value;
    endfunction

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected)
        begin
            $display("Error at %0t: %s, got %0h, expected %0h", $time, what, actual, expected);
            errors++;
        end
    endtask

    // ==================================================
    // Per-cycle client, memory model and scoreboard
    // ==================================================

    // Everything is sampled at the rising edge and driven back with NBAs
    always @(posedge clk)
    begin : model_step
        int                pick;
        int                occupancy;
        logic              busy;
        rob_pkg::t_rob_idx slot;
        rob_pkg::t_rd_req  req;
        rob_pkg::t_rd_req  exp;
        rob_pkg::t_rd_rsp  rsp;
        if (!reset)
        begin
            // A dequeue shows on client_rsp.valid two cycles later
            // So the store occupancy two edges back is what the client still lacks
            if (hist_count == 2)
            begin
                occupancy = issued_hist[1] - received;
                check_value(occupancy <= `ROB_ENTRIES, 1'b1,
                            "outstanding reads within ROB_ENTRIES");
                check_value(af_hist[1],
                            occupancy >= `ROB_ENTRIES - `ROB_MIN_FREE || maf_hist[1],
                            "client_almost_full");
            end
            else
            begin
                hist_count++;
            end
            issued_hist[1] = issued_hist[0];
            af_hist[1]     = af_hist[0];
            maf_hist[1]    = maf_hist[0];
            issued_hist[0] = issued;
            af_hist[0]     = client_almost_full;
            maf_hist[0]    = mem_almost_full;

            // A request on the bus is taken at this edge
            check_value(mem_req.valid, client_req.valid, "mem_req.valid");
            if (client_req.valid)
            begin
                check_value(mem_req.addr, client_req.addr, "mem_req.addr");
                check_value(mem_req.mdata < `ROB_ENTRIES, 1'b1, "mem_req.mdata is a slot index");
                slot = rob_pkg::t_rob_idx'(mem_req.mdata);
                busy = 1'b0;
                foreach (pending_q[i])
                begin
                    if (pending_q[i] == slot)
                    begin
                        busy = 1'b1;
                    end
                end
                check_value(busy, 1'b0, "mem_req.mdata names a slot still pending");
                pending_q.push_back(slot);
                slot_addr[slot] = client_req.addr;
                expected_q.push_back(client_req);
                issued <= issued + 1;
            end

            // Responses must come back in request order with the client's tag
            if (client_rsp.valid)
            begin
                if (expected_q.size() == 0)
                begin
                    $display("A client response arrived with no request outstanding");
                    errors++;
                end
                else
                begin
                    exp = expected_q.pop_front();
                    check_value(client_rsp.mdata, exp.mdata, "client_rsp.mdata");
                    check_value(client_rsp.data, rob_pkg::t_line'(exp.addr) ^ DATA_KEY,
                                "client_rsp.data");
                    check_value(client_rsp.error, exp.addr[0], "client_rsp.error");
                end
                received <= received + 1;
            end

            // Memory answers a random pending slot most cycles
            if (pending_q.size() > 0 && rand_bits(2) != 0)
            begin
                pick = int'(rand_bits(8) % pending_q.size());
                slot = pending_q[pick];
                pending_q.delete(pick);
                rsp.valid = 1'b1;
                rsp.error = slot_addr[slot][0];
                rsp.mdata = rob_pkg::t_mdata'(slot);
                rsp.data  = rob_pkg::t_line'(slot_addr[slot]) ^ DATA_KEY;
                mem_rsp <= rsp;
            end
            else
            begin
                mem_rsp <= '0;
            end

            // Short random back-pressure pulses from memory
            mem_almost_full <= (rand_bits(3) == 0);

            // The client stops on the cycle after it sees almost-full
            if (issue_en && !client_almost_full && sent < NUM_REQS && rand_bits(2) != 0)
            begin
                req.valid = 1'b1;
                req.addr  = rand_bits(32);
                req.mdata = rob_pkg::t_mdata'(rand_bits(`MDATA_WIDTH));
                client_req <= req;
                sent <= sent + 1;
            end
            else
            begin
                client_req <= '0;
            end
        end
    end

    // ==================================================
    // Test sequence
    // ==================================================

    initial
    begin : sequence_main
        int   cycles;
        logic timed_out;
        clk             = 1'b0;
        reset           = 1'b1;
        client_req      = '0;
        mem_rsp         = '0;
        mem_almost_full = 1'b0;
        issue_en        = 1'b0;
        errors          = 0;
        sent            = 0;
        issued          = 0;
        received        = 0;
        hist_count      = 0;
        timed_out       = 1'b0;

        repeat (4) @(posedge clk);
        reset <= 1'b0;

        // Outputs straight after reset
        @(posedge clk);
        check_value(client_rsp.valid, 1'b0, "client_rsp.valid after reset");
        check_value(mem_req.valid, 1'b0, "mem_req.valid after reset");
        check_value(client_almost_full, mem_almost_full, "client_almost_full after reset");
        issue_en <= 1'b1;

        // Wait until the client has had every request accepted
        cycles = 0;
        while (issued < NUM_REQS && cycles < ISSUE_TIMEOUT)
        begin
            @(posedge clk);
            cycles++;
        end
        if (issued < NUM_REQS)
        begin
            $display("Timed out with only %0d of %0d requests accepted", issued, NUM_REQS);
            errors++;
            timed_out = 1'b1;
        end

        // Drain until every request has had exactly one response
        if (!timed_out)
        begin
            cycles = 0;
            while (received < issued && cycles < DRAIN_TIMEOUT)
            begin
                @(posedge clk);
                cycles++;
            end
            if (received < issued)
            begin
                $display("Timed out draining, %0d of %0d responses seen", received, issued);
                errors++;
                timed_out = 1'b1;
            end
        end

        // A few quiet cycles catch any extra response
        if (!timed_out)
        begin
            repeat (8) @(posedge clk);
            check_value(expected_q.size(), 0, "requests left without a response");
            check_value(received, issued, "responses compared with requests");
        end

        $display("Requests %0d, responses %0d, errors %0d", issued, received, errors);
        if (errors == 0)
        begin
            $display("Done: no errors");
        end
        else
        begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* files.f */
+incdir+include
src/rob_pkg.sv
src/rd_req_tagger.sv
src/rob_store.sv
src/rd_rsp_sequencer.sv
src/rob_rd_shim.sv
testbench/tb_rob_rd_shim.sv

/* Makefile */
# Verilator build and run for the read-response reorder shim

VERILATOR ?= verilator
TOP       ?= tb_rob_rd_shim
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

# Sources come from the file list; the header is a dependency as well
SRCS    := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard include/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# The binary is rebuilt only when a source, header or the file list changes
$(BIN): $(SRCS) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass or fail is decided by the pass message in the log
run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^Done: no errors$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
